// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_mem_access
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: access_decode.sv
// Access decode
// Byte selects, mask, region and alignment
`default_nettype none

module access_decode #(
   parameter bit SRAM_EN = 1'b1
) (
   input  wire mem_access_pkg::mem_cmd_t cmd,
   output mem_access_pkg::mem_dec_t      dec
);

   import mem_access_pkg::*;

   logic [1:0]  ofs;        // Byte offset in the word
   logic [3:0]  sel;
   logic [31:0] lanes;      // Store data on its lanes
   logic        misaligned;
   region_e     region;

   assign ofs = cmd.addr[1:0];

   // Size and offset table
   always_comb begin
      case (cmd.size)
         SIZE_B: begin
            sel   = 4'b0001 << ofs;           // One lane
            lanes = {4{cmd.wdata[7:0]}};      // Byte on every lane
         end
         SIZE_H: begin
            sel   = ofs[1] ? 4'b1100 : 4'b0011;
            lanes = {2{cmd.wdata[15:0]}};
         end
         default: begin
            sel   = 4'b1111;                  // Whole word
            lanes = cmd.wdata;
         end
      endcase
   end

   // Half needs even address, word needs offset 0
   always_comb begin
      case (cmd.size)
         SIZE_H:  misaligned = ofs[0];
         SIZE_W:  misaligned = |ofs;
         default: misaligned = 1'b0;
      endcase
   end

   // Region from the top nibble
   always_comb begin
      if (cmd.addr[31])
         region = SRAM_EN ? REG_SRAM : REG_NONE; // No SRAM fitted
      else if (cmd.addr[30])
         region = REG_IO;
      else if (cmd.addr[29:28] == 2'b10)
         region = REG_CTRL;
      else
         region = REG_NONE;
   end

   always_comb begin
      dec.is_store   = cmd.is_store;
      dec.size       = cmd.size;
      dec.is_signed  = cmd.is_signed;
      dec.addr       = cmd.addr;
      dec.wdata      = lanes;
      dec.sel        = sel;
      dec.bmask      = ~sel; // Active low copy
      dec.region     = region;
      dec.misaligned = misaligned;
   end

endmodule

`default_nettype wire

// File: bus_cycle_ctrl.sv
// Bus cycle control
// Strobes, write enables and ack wait
`default_nettype none

module bus_cycle_ctrl (
   input  wire logic                     clk,
   input  wire logic                     RST_I,
   input  wire logic                     dec_valid,
   output logic                          dec_ready,
   input  wire mem_access_pkg::mem_dec_t dec,
   output mem_access_pkg::mem_bus_t      bus,
   output logic                          io_stb,
   output logic                          sram_stb,
   output logic                          ctrl_we,
   input  wire logic                     io_ack,
   input  wire logic                     sram_ack,
   input  wire logic                     bus_err,
   input  wire logic [31:0]              rdata_in,
   output logic                          raw_valid,
   input  wire logic                     raw_ready,
   output mem_access_pkg::mem_raw_t      raw
);

   import mem_access_pkg::*;

   typedef enum logic {IDLE, WAIT} state_e;

   state_e       state;
   logic         accept;
   logic         go_bus;    // Aligned SRAM or I/O access
   logic         end_cycle; // Matching ack or bus error in WAIT
   logic [31:0]  adr_q;
   logic [31:0]  dat_q;
   logic [3:0]   sel_q;
   logic         we_q;
   logic [1:0]   ofs_q;     // Kept for the raw response
   access_size_e size_q;
   logic         signed_q;
   logic         store_q;
   status_e      imm_status;

   assign go_bus = ~dec.misaligned & (dec.region == REG_SRAM | dec.region == REG_IO);

   // Only take a command when the stage behind has room
   assign dec_ready = (state == IDLE) & raw_ready;
   assign accept    = dec_valid & dec_ready;
   assign end_cycle = (state == WAIT) &
                      ((io_stb & io_ack) | (sram_stb & sram_ack) | bus_err);

   always_ff @(posedge clk) begin
      if (RST_I) begin
         state    <= IDLE;
         io_stb   <= 1'b0;
         sram_stb <= 1'b0;
         we_q     <= 1'b0;
         ctrl_we  <= 1'b0;
      end else begin
         ctrl_we <= accept & ~dec.misaligned & dec.is_store & (dec.region == REG_CTRL); // One cycle
         if (accept & go_bus) begin
            state    <= WAIT;
            io_stb   <= (dec.region == REG_IO);
            sram_stb <= (dec.region == REG_SRAM);
            we_q     <= dec.is_store;
         end else if (end_cycle) begin // Ack or bus error ends the strobe
            state    <= IDLE;
            io_stb   <= 1'b0;
            sram_stb <= 1'b0;
            we_q     <= 1'b0;
         end
      end
   end

   // Address, lanes and access details held through WAIT
   always_ff @(posedge clk) begin
      if (accept) begin
         adr_q    <= dec.addr;
         dat_q    <= dec.wdata;
         sel_q    <= dec.sel;
         ofs_q    <= dec.addr[1:0];
         size_q   <= dec.size;
         signed_q <= dec.is_signed;
         store_q  <= dec.is_store;
      end
   end

   assign bus.adr = adr_q;
   assign bus.dat = dat_q;
   assign bus.sel = sel_q;
   assign bus.we  = we_q;

   always_comb begin
      if (dec.misaligned)             imm_status = ST_MISALIGNED;
      else if (dec.region == REG_NONE) imm_status = ST_BUSERR; // Unmapped
      else                            imm_status = ST_OK;
   end

   // CTRL, unmapped and misaligned complete on the accept edge
   assign raw_valid = ((state == IDLE) & dec_valid & ~go_bus) | end_cycle;

   always_comb begin
      if (state == WAIT) begin
         raw.rsp.rdata     = rdata_in; // Sampled by the stage on the ack edge
         raw.rsp.status    = bus_err ? ST_BUSERR : ST_OK;
         raw.rsp.was_store = store_q;
         raw.offset        = ofs_q;
         raw.size          = size_q;
         raw.is_signed     = signed_q;
      end else begin
         raw.rsp.rdata     = '0;       // No read path for these
         raw.rsp.status    = imm_status;
         raw.rsp.was_store = dec.is_store;
         raw.offset        = dec.addr[1:0];
         raw.size          = dec.size;
         raw.is_signed     = dec.is_signed;
      end
   end

endmodule

`default_nettype wire

// File: load_align.sv
// Load data alignment and extension
`default_nettype none

module load_align (
   input  wire mem_access_pkg::mem_raw_t raw,
   input  wire logic                     raw_valid,
   output logic                          raw_ready,
   output mem_access_pkg::mem_rsp_t      rsp,
   output logic                          rsp_valid,
   input  wire logic                     rsp_ready
);

   import mem_access_pkg::*;

   logic [31:0] lanes; // Raw data moved down to lane 0
   logic [31:0] ext;   // After size mask and extension
   logic        zero;  // Stores and errors carry no data

   assign rsp_valid = raw_valid;
   assign raw_ready = rsp_ready;

   assign lanes = raw.rsp.rdata >> {raw.offset, 3'b000};
   assign zero  = raw.rsp.was_store | (raw.rsp.status != ST_OK);

   always_comb begin
      case (raw.size)
         SIZE_B: begin
            if (raw.is_signed)
               ext = {{24{lanes[7]}}, lanes[7:0]};   // Sign bit 7
            else
               ext = {24'h0, lanes[7:0]};
         end
         SIZE_H: begin
            if (raw.is_signed)
               ext = {{16{lanes[15]}}, lanes[15:0]}; // Sign bit 15
            else
               ext = {16'h0, lanes[15:0]};
         end
         default: ext = lanes;
      endcase
   end

   always_comb begin
      rsp.rdata     = zero ? 32'h0 : ext;
      rsp.status    = raw.rsp.status;
      rsp.was_store = raw.rsp.was_store;
   end

endmodule

`default_nettype wire

// File: mem_access_pkg.sv
// Load/store access unit
// Shared types
`default_nettype none

package mem_access_pkg;

   typedef enum logic [1:0] {
      SIZE_B = 2'd0, // Byte
      SIZE_H = 2'd1, // Half word
      SIZE_W = 2'd2  // Word
   } access_size_e;

   // Region from the top address nibble
   typedef enum logic [1:0] {
      REG_SRAM = 2'd0, // 1xxx
      REG_IO   = 2'd1, // 01xx
      REG_CTRL = 2'd2, // 0010
      REG_NONE = 2'd3  // Unmapped
   } region_e;

   typedef enum logic [1:0] {
      ST_OK         = 2'd0,
      ST_MISALIGNED = 2'd1,
      ST_BUSERR     = 2'd2
   } status_e;

   // Command from the core
   typedef struct packed {
      logic         is_store;
      access_size_e size;
      logic         is_signed;
      logic [31:0]  addr;
      logic [31:0]  wdata;   // Right aligned store data
   } mem_cmd_t;

   typedef struct packed {
      logic         is_store;
      access_size_e size;
      logic         is_signed;
      logic [31:0]  addr;
      logic [31:0]  wdata;      // Already copied onto its lanes
      logic [3:0]   sel;        // Byte selects
      logic [3:0]   bmask;      // Active low byte mask
      region_e      region;
      logic         misaligned;
   } mem_dec_t;

   typedef struct packed {
      logic [31:0] rdata;
      status_e     status;
      logic        was_store;
   } mem_rsp_t;

   // Raw lane data plus what the result stage needs to align it
   typedef struct packed {
      mem_rsp_t     rsp;
      logic [1:0]   offset;
      access_size_e size;
      logic         is_signed;
   } mem_raw_t;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
   } mem_bus_t;

endpackage

`default_nettype wire

// File: mem_access_top.sv
// Load/store access unit top
`default_nettype none

module mem_access_top #(
   parameter bit SRAM_EN     = 1'b1,
   parameter int STAGE_DEPTH = 2
) (
   input  wire logic                     clk,
   input  wire logic                     RST_I,
   input  wire logic                     cmd_valid,
   output logic                          cmd_ready,
   input  wire mem_access_pkg::mem_cmd_t cmd,
   output logic                          rsp_valid,
   input  wire logic                     rsp_ready,
   output mem_access_pkg::mem_rsp_t      rsp,
   output mem_access_pkg::mem_bus_t      bus,
   output logic                          io_stb,
   output logic                          sram_stb,
   output logic                          ctrl_we,
   input  wire logic                     io_ack,
   input  wire logic                     sram_ack,
   input  wire logic                     bus_err,
   input  wire logic [31:0]              rdata_in
);

   import mem_access_pkg::*;

   mem_dec_t dec_d;       // Decode output
   mem_dec_t dec_q;       // Stage toward execute
   logic     dec_q_valid;
   logic     dec_q_ready;
   mem_raw_t raw_d;       // Execute output
   mem_raw_t raw_q;       // Stage toward result
   logic     raw_d_valid;
   logic     raw_d_ready;
   logic     raw_q_valid;
   logic     raw_q_ready;

   access_decode #(.SRAM_EN(SRAM_EN)) access_decode_inst (
      .cmd (cmd),
      .dec (dec_d)
   );

   pipe_stage #(.payload_t(mem_dec_t), .DEPTH(STAGE_DEPTH)) dec_stage_inst (
      .clk (clk), .RST_I (RST_I),
      .in_valid (cmd_valid), .in_ready (cmd_ready), .in_data (dec_d),
      .out_valid (dec_q_valid), .out_ready (dec_q_ready), .out_data (dec_q)
   );

   bus_cycle_ctrl bus_cycle_ctrl_inst (
      .clk (clk), .RST_I (RST_I),
      .dec_valid (dec_q_valid), .dec_ready (dec_q_ready), .dec (dec_q),
      .bus (bus), .io_stb (io_stb), .sram_stb (sram_stb), .ctrl_we (ctrl_we),
      .io_ack (io_ack), .sram_ack (sram_ack), .bus_err (bus_err), .rdata_in (rdata_in),
      .raw_valid (raw_d_valid), .raw_ready (raw_d_ready), .raw (raw_d)
   );

   pipe_stage #(.payload_t(mem_raw_t), .DEPTH(STAGE_DEPTH)) raw_stage_inst (
      .clk (clk), .RST_I (RST_I),
      .in_valid (raw_d_valid), .in_ready (raw_d_ready), .in_data (raw_d),
      .out_valid (raw_q_valid), .out_ready (raw_q_ready), .out_data (raw_q)
   );

   load_align load_align_inst (
      .raw (raw_q), .raw_valid (raw_q_valid), .raw_ready (raw_q_ready),
      .rsp (rsp), .rsp_valid (rsp_valid), .rsp_ready (rsp_ready)
   );

endmodule

`default_nettype wire

// File: pipe_stage.sv
// Valid/ready stage with a small circular FIFO
`default_nettype none

module pipe_stage #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 2
) (
   input  wire logic     clk,
   input  wire logic     RST_I,
   input  wire logic     in_valid,
   output logic          in_ready,
   input  wire payload_t in_data,
   output logic          out_valid,
   input  wire logic     out_ready,
   output payload_t      out_data
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
   localparam int CW = $clog2(DEPTH + 1);               // Count width

   payload_t        mem [DEPTH]; // Entries
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            push;
   logic            pop;

   assign in_ready  = (count != CW'(DEPTH)); // Low when full
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk) begin
      if (RST_I) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
         if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push & ~pop)      count <= count + 1'b1;
         else if (pop & ~push) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic RST_I
);

   initial begin
      clk   = 1'b0;
      RST_I = 1'b1;        // Held for three rising edges
      repeat (3) @(posedge clk);
      RST_I <= 1'b0;
   end

   always #4 clk = ~clk;   // Period 8

endmodule

`default_nettype wire

// File: tb_mem_access.sv
// Load/store access unit testbench
`default_nettype none

module tb_mem_access;

   import mem_access_pkg::*;

   localparam int NUM = 20;   // Table entries
   localparam int TO  = 200;  // Cycles per wait

   typedef struct packed {
      mem_cmd_t    cmd;
      status_e     st;        // Expected status
      logic [31:0] rdata;     // Expected load data
   } vec_t;

   logic        clk;
   logic        RST_I;
   logic        cmd_valid = 1'b0;
   logic        cmd_ready;
   mem_cmd_t    cmd = '0;
   logic        rsp_valid;
   logic        rsp_ready = 1'b0;
   mem_rsp_t    rsp;
   mem_bus_t    bus;
   logic        io_stb;
   logic        sram_stb;
   logic        ctrl_we;
   logic        io_ack = 1'b0;
   logic        sram_ack = 1'b0;
   logic        bus_err = 1'b0;
   logic [31:0] rdata_in = '0;

   vec_t        tbl [NUM];
   logic [31:0] sram [64];
   logic [31:0] lat_rng = 32'hce04_0b01;
   logic [31:0] rdy_rng = 32'hce04_0b01 ^ 32'h1234_5678; // Second stream
   logic [1:0]  delay = '0;
   logic        busy = 1'b0;          // Responder counting down
   logic        stb_prev = 1'b0;
   logic        timed_out = 1'b0;
   int          stb_count = 0;
   int          ctrl_count = 0;
   int          mon_errors = 0;
   int          chk_errors = 0;
   int          passed = 0;
   logic [3:0]  ctrl_sel [$];         // Expected sel per CTRL store

   tb_clock_gen tb_clock_gen_inst (.clk(clk), .RST_I(RST_I));

   mem_access_top #(.SRAM_EN(1'b1), .STAGE_DEPTH(2)) mem_access_top_inst (
      .clk (clk), .RST_I (RST_I),
      .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
      .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp (rsp),
      .bus (bus), .io_stb (io_stb), .sram_stb (sram_stb), .ctrl_we (ctrl_we),
      .io_ack (io_ack), .sram_ack (sram_ack), .bus_err (bus_err), .rdata_in (rdata_in)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic vec_t make_vec(input logic st_en, input access_size_e sz,
                                     input logic sgn, input logic [31:0] addr,
                                     input logic [31:0] wd, input status_e st,
                                     input logic [31:0] rd);
      vec_t v;
      v.cmd.is_store  = st_en;
      v.cmd.size      = sz;
      v.cmd.is_signed = sgn;
      v.cmd.addr      = addr;
      v.cmd.wdata     = wd;
      v.st            = st;
      v.rdata         = rd;
      return v;
   endfunction

   // SRAM and I/O responders with bus error on I/O nibble E in bits 27:24
   always @(posedge clk) begin
      io_ack   <= 1'b0;
      sram_ack <= 1'b0;
      bus_err  <= 1'b0;
      if (!RST_I && (sram_stb | io_stb) && !(sram_ack | io_ack | bus_err)) begin
         if (!busy) begin
            busy    <= 1'b1;
            delay   <= lat_rng[1:0];            // 0 to 3 extra cycles
            lat_rng <= xorshift(lat_rng);
         end else if (delay != 0) begin
            delay <= delay - 1'b1;
         end else begin
            busy <= 1'b0;
            if (io_stb && bus.adr[27:24] == 4'he) begin
               bus_err <= 1'b1;
            end else if (sram_stb) begin
               sram_ack <= 1'b1;
               rdata_in <= sram[bus.adr[7:2]];
               if (bus.we) begin
                  for (int b = 0; b < 4; b++)
                     if (bus.sel[b]) sram[bus.adr[7:2]][8*b +: 8] <= bus.dat[8*b +: 8];
               end
            end else begin
               io_ack   <= 1'b1;
               rdata_in <= bus.adr ^ 32'h5a5a_0000;
            end
         end
      end
   end

   // Random back-pressure on the response side
   always @(posedge clk) begin
      rdy_rng   <= xorshift(rdy_rng);
      rsp_ready <= (rdy_rng[2:0] != 3'd0) && (rdy_rng[5:4] != 2'd3);
   end

   // Strobe, we and ctrl_we monitor
   always @(negedge clk) begin
      if (!RST_I) begin
         stb_prev <= sram_stb | io_stb;
         if ((sram_stb | io_stb) && !stb_prev) stb_count <= stb_count + 1;
         if (bus.we && !(sram_stb | io_stb)) begin
            $display("we seen with no strobe raised");
            mon_errors <= mon_errors + 1;
         end
         if (ctrl_we) begin
            ctrl_count <= ctrl_count + 1;
            if (ctrl_sel.size() == 0) begin
               $display("ctrl_we pulse with no CTRL store pending");
               mon_errors <= mon_errors + 1;
            end else if (bus.sel != ctrl_sel[0]) begin
               $display("FAILED bus.sel got %h expected %h", bus.sel, ctrl_sel[0]);
               mon_errors <= mon_errors + 1;
               void'(ctrl_sel.pop_front());
            end else begin
               void'(ctrl_sel.pop_front());
            end
         end
      end
   end

   task automatic send_all();
      int t;
      for (int i = 0; i < NUM; i++) begin
         cmd       <= tbl[i].cmd;
         cmd_valid <= 1'b1;
         t = 0;
         do begin
            @(negedge clk);
            t++;
         end while (!cmd_ready && t < TO);
         if (!cmd_ready) begin
            $display("entry %0d never accepted", i);
            timed_out = 1'b1;
            break;
         end
         @(posedge clk);
      end
      cmd_valid <= 1'b0;
   endtask

   task automatic check_all();
      int t;
      for (int i = 0; i < NUM; i++) begin
         t = 0;
         do begin
            @(negedge clk);
            t++;
         end while (!(rsp_valid && rsp_ready) && t < TO);
         if (!(rsp_valid && rsp_ready)) begin
            $display("no response for entry %0d", i);
            timed_out = 1'b1;
            break;
         end
         if (rsp.status != tbl[i].st) begin
            $display("FAILED entry %0d rsp.status got %h expected %h", i, rsp.status, tbl[i].st);
            chk_errors++;
         end else if (rsp.rdata != tbl[i].rdata) begin
            $display("FAILED entry %0d rsp.rdata got %h expected %h", i, rsp.rdata, tbl[i].rdata);
            chk_errors++;
         end else if (rsp.was_store != tbl[i].cmd.is_store) begin
            $display("FAILED entry %0d rsp.was_store got %h expected %h",
                     i, rsp.was_store, tbl[i].cmd.is_store);
            chk_errors++;
         end else begin
            $display("entry %0d ok", i);
            passed++;
         end
         @(posedge clk);
      end
   endtask

   initial begin
      int t;
      for (int i = 0; i < 64; i++) sram[i] = 32'h5eed_0000 + i; // Index in every word
      tbl[0]  = make_vec(1, SIZE_W, 0, 32'h8000_0010, 32'h8765_4321, ST_OK, 32'h0);
      tbl[1]  = make_vec(1, SIZE_H, 0, 32'h8000_0012, 32'h0000_beef, ST_OK, 32'h0);
      tbl[2]  = make_vec(1, SIZE_B, 0, 32'h8000_0011, 32'h0000_00a5, ST_OK, 32'h0);
      tbl[3]  = make_vec(0, SIZE_W, 0, 32'h8000_0010, 32'h0, ST_OK, 32'hbeef_a521);
      tbl[4]  = make_vec(0, SIZE_H, 1, 32'h8000_0012, 32'h0, ST_OK, 32'hffff_beef);
      tbl[5]  = make_vec(0, SIZE_H, 0, 32'h8000_0012, 32'h0, ST_OK, 32'h0000_beef);
      tbl[6]  = make_vec(0, SIZE_B, 1, 32'h8000_0011, 32'h0, ST_OK, 32'hffff_ffa5);
      tbl[7]  = make_vec(0, SIZE_B, 0, 32'h8000_0013, 32'h0, ST_OK, 32'h0000_00be);
      tbl[8]  = make_vec(0, SIZE_B, 1, 32'h8000_0010, 32'h0, ST_OK, 32'h0000_0021);
      tbl[9]  = make_vec(0, SIZE_W, 0, 32'h4000_0020, 32'h0, ST_OK, 32'h1a5a_0020);
      tbl[10] = make_vec(0, SIZE_H, 0, 32'h4000_0022, 32'h0, ST_OK, 32'h0000_1a5a);
      tbl[11] = make_vec(0, SIZE_B, 1, 32'h4000_8001, 32'h0, ST_OK, 32'hffff_ff80);
      tbl[12] = make_vec(0, SIZE_H, 0, 32'h8000_0011, 32'h0, ST_MISALIGNED, 32'h0);
      tbl[13] = make_vec(1, SIZE_W, 0, 32'h4000_0022, 32'h1111_2222, ST_MISALIGNED, 32'h0);
      tbl[14] = make_vec(0, SIZE_W, 0, 32'h1000_0000, 32'h0, ST_BUSERR, 32'h0);
      tbl[15] = make_vec(0, SIZE_W, 0, 32'h4e00_0000, 32'h0, ST_BUSERR, 32'h0);
      tbl[16] = make_vec(1, SIZE_B, 0, 32'h2000_0003, 32'h0000_0077, ST_OK, 32'h0);
      tbl[17] = make_vec(1, SIZE_H, 0, 32'h2000_0002, 32'h0000_1234, ST_OK, 32'h0);
      tbl[18] = make_vec(0, SIZE_W, 0, 32'h2000_0000, 32'h0, ST_OK, 32'h0);
      tbl[19] = make_vec(0, SIZE_W, 0, 32'h8000_0010, 32'h0, ST_OK, 32'hbeef_a521);
      ctrl_sel.push_back(4'b1000);
      ctrl_sel.push_back(4'b1100);
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (RST_I && t < TO);
      if (RST_I) begin
         $display("reset never released");
         timed_out = 1'b1;
      end else begin
         fork
            send_all();
            check_all();
         join
      end
      repeat (5) @(negedge clk);
      if (rsp_valid) begin
         $display("response left over after the last entry");
         chk_errors++;
      end
      if (stb_count != 14) begin
         $display("FAILED stb_count got %h expected %h", stb_count, 14);
         chk_errors++;
      end
      if (ctrl_count != 2) begin
         $display("FAILED ctrl_we count got %h expected %h", ctrl_count, 2);
         chk_errors++;
      end
      $display("%0d passed, %0d failed, %0d monitor errors", passed, chk_errors, mon_errors);
      if (chk_errors == 0 && mon_errors == 0 && !timed_out) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
mem_access_pkg.sv
pipe_stage.sv
access_decode.sv
bus_cycle_ctrl.sv
load_align.sv
mem_access_top.sv
tb_clock_gen.sv
tb_mem_access.sv
